//--- Bender.yml
package:
  name: msu

sources:
  - msu_pkg.sv
  - msu_host_sync.sv
  - msu_databuf.sv
  - msu_regs.sv
  - msu_read_port.sv
  - msu.sv
  - target: test
    files:
      - msu_checker.sv
      - tb_msu.sv

//--- files.f
msu_pkg.sv
msu_host_sync.sv
msu_databuf.sv
msu_regs.sv
msu_read_port.sv
msu.sv
msu_checker.sv
tb_msu.sv

//--- msu.sv
`timescale 1ns/1ps

module msu (
  input  logic                          clkin,
  input  logic                          rst,
  input  logic                          enable,
  input  logic [msu_pkg::msu_buf_aw-1:0] pgm_address,
  input  logic [7:0]                    pgm_data,
  input  logic                          pgm_we,
  input  logic [msu_pkg::msu_reg_aw-1:0] reg_addr,
  input  logic [7:0]                    reg_data_in,
  output logic [7:0]                    reg_data_out,
  input  logic                          reg_oe_falling,
  input  logic                          reg_oe_rising,
  input  logic                          reg_we_rising,
  output logic [6:0]                    status_out,
  output logic [7:0]                    volume_out,
  output logic                          volume_latch_out,
  output logic [31:0]                   addr_out,
  output logic [15:0]                   track_out,
  input  logic [5:0]                    status_set_bits,
  input  logic [5:0]                    status_reset_bits,
  input  logic                          status_reset_we,
  input  logic [msu_pkg::msu_buf_aw-1:0] msu_address_ext,
  input  logic                          msu_address_ext_write
);

  import msu_pkg::*;

  logic                  rd_latch;
  logic                  rd_done;
  logic                  wr_strobe;
  logic                  status_update;
  logic                  ptr_load;
  logic                  audio_start;
  logic                  data_start;
  logic                  ctrl_start;
  logic                  audio_busy;
  logic                  data_busy;
  logic                  audio_error;
  logic [1:0]            audio_ctrl;
  logic [1:0]            audio_status;
  logic [msu_buf_aw-1:0] buf_addr;
  logic [7:0]            buf_rdata;

  msu_host_sync i_host_sync (
    .clkin                 (clkin),
    .rst                   (rst),
    .enable                (enable),
    .reg_oe_falling        (reg_oe_falling),
    .reg_oe_rising         (reg_oe_rising),
    .reg_we_rising         (reg_we_rising),
    .status_reset_we       (status_reset_we),
    .msu_address_ext_write (msu_address_ext_write),
    .rd_latch              (rd_latch),
    .rd_done               (rd_done),
    .wr_strobe             (wr_strobe),
    .status_update         (status_update),
    .ptr_load              (ptr_load)
  );

  msu_regs i_regs (
    .clkin             (clkin),
    .rst               (rst),
    .wr_strobe         (wr_strobe),
    .status_update     (status_update),
    .reg_addr          (reg_addr),
    .reg_data_in       (reg_data_in),
    .status_set_bits   (status_set_bits),
    .status_reset_bits (status_reset_bits),
    .addr_out          (addr_out),
    .track_out         (track_out),
    .volume_out        (volume_out),
    .volume_latch_out  (volume_latch_out),
    .audio_start       (audio_start),
    .data_start        (data_start),
    .ctrl_start        (ctrl_start),
    .audio_busy        (audio_busy),
    .data_busy         (data_busy),
    .audio_error       (audio_error),
    .audio_ctrl        (audio_ctrl),
    .audio_status      (audio_status)
  );

  // Write enable from the MCU side is active low
  msu_databuf i_databuf (
    .clkin (clkin),
    .we    (~pgm_we),
    .waddr (pgm_address),
    .wdata (pgm_data),
    .raddr (buf_addr),
    .rdata (buf_rdata)
  );

  msu_read_port i_read_port (
    .clkin           (clkin),
    .rst             (rst),
    .rd_latch        (rd_latch),
    .rd_done         (rd_done),
    .ptr_load        (ptr_load),
    .reg_addr        (reg_addr),
    .msu_address_ext (msu_address_ext),
    .buf_data        (buf_rdata),
    .data_busy       (data_busy),
    .audio_busy      (audio_busy),
    .audio_error     (audio_error),
    .audio_status    (audio_status),
    .buf_addr        (buf_addr),
    .reg_data_out    (reg_data_out)
  );

  // Pointer MSB tells the MCU which buffer half is being drained
  assign status_out = {buf_addr[msu_buf_aw-1],
                       audio_start,
                       data_start,
                       volume_latch_out,
                       audio_ctrl,
                       ctrl_start};

endmodule

//--- msu_checker.sv
`timescale 1ns/1ps

module msu_checker (
  input logic                          clkin,
  input logic                          rst,
  input logic                          wr_strobe,
  input logic                          status_update,
  input logic                          audio_busy,
  input logic                          volume_latch_out,
  input logic [msu_pkg::msu_reg_aw-1:0] reg_addr,
  input logic [1:0]                    audio_ctrl,
  input logic [6:0]                    status_out
);

  import msu_pkg::*;

  int unsigned violations = 0;

  //////////////////////////////////////////////////
  // Register block rules
  //////////////////////////////////////////////////

  // Audio start comes only from the console's track write
  audio_start_src: assert property (@(posedge clkin) disable iff (rst)
    $rose(status_out[5]) |-> $past(wr_strobe && (reg_addr == reg_track1)))
    else begin
      $error("audio start flag rose without a write to track register 1");
      violations++;
    end

  // Control bits frozen while a track is loading
  ctrl_frozen_busy: assert property (@(posedge clkin) disable iff (rst)
    (audio_busy && !status_update) |=> $stable(audio_ctrl))
    else begin
      $error("audio control bits changed while audio busy was set");
      violations++;
    end

  volume_after_reset: assert property (@(posedge clkin)
    rst |=> !volume_latch_out)
    else begin
      $error("volume latch pulse seen right after reset");
      violations++;
    end

endmodule

bind msu msu_checker i_checker (
  .clkin            (clkin),
  .rst              (rst),
  .wr_strobe        (wr_strobe),
  .status_update    (status_update),
  .audio_busy       (audio_busy),
  .volume_latch_out (volume_latch_out),
  .reg_addr         (reg_addr),
  .audio_ctrl       (audio_ctrl),
  .status_out       (status_out)
);

//--- msu_databuf.sv
`timescale 1ns/1ps

module msu_databuf (
  input  logic                          clkin,
  input  logic                          we,
  input  logic [msu_pkg::msu_buf_aw-1:0] waddr,
  input  logic [7:0]                    wdata,
  input  logic [msu_pkg::msu_buf_aw-1:0] raddr,
  output logic [7:0]                    rdata
);

  import msu_pkg::*;

  logic [7:0] mem [msu_buf_depth];

  // MCU fill port
  always_ff @(posedge clkin) begin
    if (we) begin
      mem[waddr] <= wdata;
    end
  end

  // Registered read, one cycle behind raddr
  always_ff @(posedge clkin) begin
    rdata <= mem[raddr];
  end

endmodule

//--- msu_host_sync.sv
`timescale 1ns/1ps

module msu_host_sync (
  input  logic clkin,
  input  logic rst,
  input  logic enable,
  input  logic reg_oe_falling,
  input  logic reg_oe_rising,
  input  logic reg_we_rising,
  input  logic status_reset_we,
  input  logic msu_address_ext_write,
  output logic rd_latch,
  output logic rd_done,
  output logic wr_strobe,
  output logic status_update,
  output logic ptr_load
);

  logic [1:0] status_we_sreg;
  logic [2:0] ext_write_sreg;

  // Console strobes are already single-cycle pulses
  assign rd_latch = reg_oe_falling & enable;
  assign rd_done = reg_oe_rising & enable;
  assign wr_strobe = reg_we_rising & enable;

  //////////////////////////////////////////////////
  // MCU level to pulse conversion
  //////////////////////////////////////////////////

  always_ff @(posedge clkin) begin
    if (rst) begin
      status_we_sreg <= '0;
      ext_write_sreg <= '0;
    end else begin
      status_we_sreg <= {status_we_sreg[0], status_reset_we};
      ext_write_sreg <= {ext_write_sreg[1:0], msu_address_ext_write};
    end
  end

  // Rising edge, one cycle wide
  assign status_update = (status_we_sreg == 2'b01);

  // Extra stage so the pointer value has settled before it is taken
  assign ptr_load = (ext_write_sreg[2:1] == 2'b01);

endmodule

//--- msu_pkg.sv
package msu_pkg;

  //////////////////////////////////////////////////
  // Sizes
  //////////////////////////////////////////////////

  // 16 KiB streaming buffer
  localparam int msu_buf_aw = 14;
  localparam int msu_buf_depth = 1 << msu_buf_aw;

  // Eight byte registers on the console side
  localparam int msu_reg_aw = 3;

  //////////////////////////////////////////////////
  // Register map
  //////////////////////////////////////////////////

  // Read meanings
  localparam logic [msu_reg_aw-1:0] reg_status = 3'd0;
  localparam logic [msu_reg_aw-1:0] reg_data = 3'd1;

  // Write meanings, same indices as the read side
  localparam logic [msu_reg_aw-1:0] reg_seek0 = 3'd0;
  localparam logic [msu_reg_aw-1:0] reg_seek1 = 3'd1;
  localparam logic [msu_reg_aw-1:0] reg_seek2 = 3'd2;
  localparam logic [msu_reg_aw-1:0] reg_seek3 = 3'd3;
  localparam logic [msu_reg_aw-1:0] reg_track0 = 3'd4;
  localparam logic [msu_reg_aw-1:0] reg_track1 = 3'd5;
  localparam logic [msu_reg_aw-1:0] reg_volume = 3'd6;
  localparam logic [msu_reg_aw-1:0] reg_control = 3'd7;

  // Bit positions in the MCU set/reset words
  localparam int sb_audio_busy = 5;
  localparam int sb_data_busy = 4;
  localparam int sb_audio_error = 3;
  localparam int sb_audio_status_hi = 2;
  localparam int sb_audio_status_lo = 1;
  localparam int sb_ctrl_start = 0;

  // "S-MSU1", index 0 answers at register 2
  localparam logic [0:5][7:0] msu_id = {8'h53, 8'h2D, 8'h4D, 8'h53, 8'h55, 8'h31};

  // Low bits of the status byte
  localparam logic [2:0] msu_revision = 3'd1;

endpackage

//--- msu_read_port.sv
`timescale 1ns/1ps

module msu_read_port (
  input  logic                          clkin,
  input  logic                          rst,
  input  logic                          rd_latch,
  input  logic                          rd_done,
  input  logic                          ptr_load,
  input  logic [msu_pkg::msu_reg_aw-1:0] reg_addr,
  input  logic [msu_pkg::msu_buf_aw-1:0] msu_address_ext,
  input  logic [7:0]                    buf_data,
  input  logic                          data_busy,
  input  logic                          audio_busy,
  input  logic                          audio_error,
  input  logic [1:0]                    audio_status,
  output logic [msu_pkg::msu_buf_aw-1:0] buf_addr,
  output logic [7:0]                    reg_data_out
);

  import msu_pkg::*;

  logic [msu_reg_aw-1:0] id_idx;
  logic [7:0]            rd_next;

  //////////////////////////////////////////////////
  // Buffer read pointer
  //////////////////////////////////////////////////

  // MCU load beats the console's auto-increment
  always_ff @(posedge clkin) begin
    if (rst) begin
      buf_addr <= '0;
    end else if (ptr_load) begin
      buf_addr <= msu_address_ext;
    end else if (rd_done && (reg_addr == reg_data)) begin
      buf_addr <= buf_addr + 1'b1;
    end
  end

  //////////////////////////////////////////////////
  // Read data select
  //////////////////////////////////////////////////

  // ID string starts at register 2
  assign id_idx = reg_addr - 3'd2;

  always_comb begin
    case (reg_addr)
      reg_status: rd_next = {data_busy, audio_busy, audio_status, audio_error, msu_revision};
      reg_data:   rd_next = buf_data;
      default:    rd_next = msu_id[id_idx];
    endcase
  end

  // Held for the console until the next read
  always_ff @(posedge clkin) begin
    if (rst) begin
      reg_data_out <= '0;
    end else if (rd_latch) begin
      reg_data_out <= rd_next;
    end
  end

endmodule

//--- msu_regs.sv
`timescale 1ns/1ps

module msu_regs (
  input  logic                          clkin,
  input  logic                          rst,
  input  logic                          wr_strobe,
  input  logic                          status_update,
  input  logic [msu_pkg::msu_reg_aw-1:0] reg_addr,
  input  logic [7:0]                    reg_data_in,
  input  logic [5:0]                    status_set_bits,
  input  logic [5:0]                    status_reset_bits,
  output logic [31:0]                   addr_out,
  output logic [15:0]                   track_out,
  output logic [7:0]                    volume_out,
  output logic                          volume_latch_out,
  output logic                          audio_start,
  output logic                          data_start,
  output logic                          ctrl_start,
  output logic                          audio_busy,
  output logic                          data_busy,
  output logic                          audio_error,
  output logic [1:0]                    audio_ctrl,
  output logic [1:0]                    audio_status
);

  import msu_pkg::*;

  logic [5:0] flags_cur;
  logic [5:0] flags_next;

  //////////////////////////////////////////////////
  // MCU set/reset word
  //////////////////////////////////////////////////

  // Flags gathered in the MCU's bit order
  always_comb begin
    flags_cur = '0;
    flags_cur[sb_audio_busy] = audio_busy;
    flags_cur[sb_data_busy] = data_busy;
    flags_cur[sb_audio_error] = audio_error;
    flags_cur[sb_audio_status_hi:sb_audio_status_lo] = audio_status;
    flags_cur[sb_ctrl_start] = ctrl_start;
    // Reset wins over set within one word
    flags_next = (flags_cur | status_set_bits) & ~status_reset_bits;
  end

  //////////////////////////////////////////////////
  // Register file
  //////////////////////////////////////////////////

  always_ff @(posedge clkin) begin
    if (rst) begin
      addr_out <= '0;
      track_out <= '0;
      volume_out <= '0;
      volume_latch_out <= 1'b0;
      audio_start <= 1'b0;
      data_start <= 1'b0;
      ctrl_start <= 1'b0;
      // Nothing streams until the MCU reports ready
      audio_busy <= 1'b1;
      data_busy <= 1'b1;
      audio_error <= 1'b0;
      audio_ctrl <= '0;
      audio_status <= '0;
    end else if (wr_strobe) begin
      case (reg_addr)
        reg_seek0: addr_out[7:0] <= reg_data_in;
        reg_seek1: addr_out[15:8] <= reg_data_in;
        reg_seek2: addr_out[23:16] <= reg_data_in;
        // Top byte completes the seek request
        reg_seek3: begin
          addr_out[31:24] <= reg_data_in;
          data_start <= 1'b1;
          data_busy <= 1'b1;
        end
        reg_track0: track_out[7:0] <= reg_data_in;
        reg_track1: begin
          track_out[15:8] <= reg_data_in;
          audio_start <= 1'b1;
          audio_busy <= 1'b1;
        end
        reg_volume: begin
          volume_out <= reg_data_in;
          volume_latch_out <= 1'b1;
        end
        // Play/repeat bits, ignored while a track is still loading
        reg_control: begin
          if (!audio_busy) begin
            audio_ctrl <= reg_data_in[1:0];
            ctrl_start <= 1'b1;
          end
        end
      endcase
    end else if (status_update) begin
      audio_busy <= flags_next[sb_audio_busy];
      data_busy <= flags_next[sb_data_busy];
      audio_error <= flags_next[sb_audio_error];
      audio_status <= flags_next[sb_audio_status_hi:sb_audio_status_lo];
      ctrl_start <= flags_next[sb_ctrl_start];
      // Clearing busy also acknowledges the start request
      if (status_reset_bits[sb_audio_busy]) begin
        audio_start <= 1'b0;
      end
      if (status_reset_bits[sb_data_busy]) begin
        data_start <= 1'b0;
      end
    end else begin
      volume_latch_out <= 1'b0;
    end
  end

endmodule

//--- tb_msu.sv
`timescale 1ns/1ps

module tb_msu;

  import msu_pkg::*;

  logic                  clkin;
  logic                  rst;
  logic                  enable;
  logic [msu_buf_aw-1:0] pgm_address;
  logic [7:0]            pgm_data;
  logic                  pgm_we;
  logic [msu_reg_aw-1:0] reg_addr;
  logic [7:0]            reg_data_in;
  logic [7:0]            reg_data_out;
  logic                  reg_oe_falling;
  logic                  reg_oe_rising;
  logic                  reg_we_rising;
  logic [6:0]            status_out;
  logic [7:0]            volume_out;
  logic                  volume_latch_out;
  logic [31:0]           addr_out;
  logic [15:0]           track_out;
  logic [5:0]            status_set_bits;
  logic [5:0]            status_reset_bits;
  logic                  status_reset_we;
  logic [msu_buf_aw-1:0] msu_address_ext;
  logic                  msu_address_ext_write;

  // Reference model of the flags, MCU bit order
  logic [5:0] exp_flags;
  logic       exp_astart;
  logic       exp_dstart;
  logic [1:0] exp_actrl;

  string test_name;
  int    errors;
  int    errors_at_start;
  int    pass_count;
  int    fail_count;

  // "S-MSU1"
  logic [7:0] id_bytes [6] = '{8'h53, 8'h2D, 8'h4D, 8'h53, 8'h55, 8'h31};

  msu i_msu (.*);

  always #4 clkin = ~clkin;

  //////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////

  task automatic check_eq(input string what, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp) else begin
      $display("[ERROR] %s %s: expected %h actual %h", test_name, what, exp, act);
      errors++;
    end
  endtask

  function automatic logic [7:0] status_byte(input logic [5:0] f);
    return {f[4], f[5], f[2:1], f[3], 3'd1};
  endfunction

  task automatic start_test(input string name);
    test_name = name;
    errors_at_start = errors;
  endtask

  task automatic finish_test();
    if (errors == errors_at_start) begin
      pass_count++;
      $display("%s: ok", test_name);
    end else begin
      fail_count++;
      $display("%s: %0d errors", test_name, errors - errors_at_start);
    end
  endtask

  task automatic bus_write(input logic [2:0] addr, input logic [7:0] data);
    @(negedge clkin);
    reg_addr = addr;
    reg_data_in = data;
    reg_we_rising = 1'b1;
    @(negedge clkin);
    reg_we_rising = 1'b0;
  endtask

  task automatic bus_read(input logic [2:0] addr, output logic [7:0] data);
    @(negedge clkin);
    reg_addr = addr;
    reg_oe_falling = 1'b1;
    @(negedge clkin);
    reg_oe_falling = 1'b0;
    data = reg_data_out;
    reg_oe_rising = 1'b1;
    @(negedge clkin);
    reg_oe_rising = 1'b0;
    // Buffer output catches up with the advanced pointer
    @(negedge clkin);
  endtask

  task automatic mcu_status(input logic [5:0] set_bits, input logic [5:0] reset_bits);
    int n;
    @(negedge clkin);
    status_set_bits = set_bits;
    status_reset_bits = reset_bits;
    status_reset_we = 1'b1;
    n = 0;
    while (!i_msu.status_update && n < 10) begin
      @(negedge clkin);
      n++;
    end
    if (!i_msu.status_update) begin
      $display("Timeout in %s: status update strobe never came", test_name);
      errors++;
    end
    // Flags change on the edge after the strobe
    @(negedge clkin);
    status_reset_we = 1'b0;
    @(negedge clkin);
    exp_flags = (exp_flags | set_bits) & ~reset_bits;
    if (reset_bits[5]) begin
      exp_astart = 1'b0;
    end
    if (reset_bits[4]) begin
      exp_dstart = 1'b0;
    end
  endtask

  task automatic mcu_load_ptr(input logic [msu_buf_aw-1:0] ptr);
    int n;
    @(negedge clkin);
    msu_address_ext = ptr;
    msu_address_ext_write = 1'b1;
    n = 0;
    while (i_msu.buf_addr !== ptr && n < 10) begin
      @(negedge clkin);
      n++;
    end
    if (i_msu.buf_addr !== ptr) begin
      $display("Timeout in %s: read pointer never took the loaded value", test_name);
      errors++;
    end
    msu_address_ext_write = 1'b0;
    @(negedge clkin);
  endtask

  task automatic pgm_byte(input logic [msu_buf_aw-1:0] addr, input logic [7:0] data);
    @(negedge clkin);
    pgm_address = addr;
    pgm_data = data;
    pgm_we = 1'b0;
    @(negedge clkin);
    pgm_we = 1'b1;
  endtask

  //////////////////////////////////////////////////
  // Tests
  //////////////////////////////////////////////////

  task automatic reset_values();
    logic [7:0] d;
    start_test("reset_values");
    bus_read(reg_status, d);
    check_eq("status byte", 8'hC1, d);
    for (int r = 2; r < 8; r++) begin
      bus_read(3'(r), d);
      check_eq($sformatf("id byte %0d", r), id_bytes[r-2], d);
    end
    check_eq("status_out", 0, status_out);
    finish_test();
  endtask

  task automatic host_writes();
    logic [31:0] seek;
    logic [15:0] track;
    logic [7:0]  vol;
    start_test("host_writes");
    seek = $urandom;
    track = 16'($urandom);
    vol = 8'($urandom);
    for (int i = 0; i < 4; i++) begin
      bus_write(3'(i), seek[8*i +: 8]);
    end
    exp_dstart = 1'b1;
    exp_flags[4] = 1'b1;
    check_eq("addr_out", seek, addr_out);
    check_eq("data start", 1, status_out[4]);
    bus_write(reg_track0, track[7:0]);
    check_eq("audio start early", 0, status_out[5]);
    bus_write(reg_track1, track[15:8]);
    exp_astart = 1'b1;
    exp_flags[5] = 1'b1;
    check_eq("track_out", track, track_out);
    check_eq("audio start", 1, status_out[5]);
    bus_write(reg_volume, vol);
    check_eq("volume_out", vol, volume_out);
    check_eq("volume latch", 1, volume_latch_out);
    check_eq("status volume bit", 1, status_out[3]);
    @(negedge clkin);
    check_eq("volume latch end", 0, volume_latch_out);
    finish_test();
  endtask

  task automatic status_set_reset();
    logic [5:0] s;
    logic [5:0] r;
    logic [7:0] d;
    start_test("status_set_reset");
    repeat (6) begin
      s = 6'($urandom);
      r = 6'($urandom);
      mcu_status(s, r);
      bus_read(reg_status, d);
      check_eq("status byte", status_byte(exp_flags), d);
      check_eq("start flags", {exp_astart, exp_dstart}, status_out[5:4]);
      check_eq("ctrl_start", exp_flags[0], status_out[0]);
    end
    // Raise both starts again, then acknowledge them
    bus_write(reg_seek3, addr_out[31:24]);
    bus_write(reg_track1, track_out[15:8]);
    exp_dstart = 1'b1;
    exp_astart = 1'b1;
    exp_flags[5:4] = 2'b11;
    check_eq("starts raised", 2'b11, status_out[5:4]);
    mcu_status(6'b000000, 6'b110000);
    check_eq("starts cleared", 2'b00, status_out[5:4]);
    bus_read(reg_status, d);
    check_eq("status byte final", status_byte(exp_flags), d);
    finish_test();
  endtask

  task automatic control_gating();
    start_test("control_gating");
    mcu_status(6'b100000, 6'b000000);
    bus_write(reg_control, 8'h03);
    check_eq("ctrl while busy", exp_actrl, status_out[2:1]);
    check_eq("ctrl_start while busy", exp_flags[0], status_out[0]);
    mcu_status(6'b000000, 6'b100001);
    bus_write(reg_control, 8'h02);
    exp_actrl = 2'b10;
    exp_flags[0] = 1'b1;
    check_eq("ctrl when idle", exp_actrl, status_out[2:1]);
    check_eq("ctrl_start when idle", 1, status_out[0]);
    finish_test();
  endtask

  task automatic buffer_stream();
    logic [msu_buf_aw-1:0] addrs [8];
    logic [7:0]            bytes [8];
    logic [7:0]            d;
    logic [msu_buf_aw-1:0] next;
    start_test("buffer_stream");
    // Crossing into the upper half, then wrapping to 0
    addrs = '{14'h1FFE, 14'h1FFF, 14'h2000, 14'h2001,
              14'h3FFE, 14'h3FFF, 14'h0000, 14'h0001};
    for (int i = 0; i < 8; i++) begin
      bytes[i] = 8'($urandom);
      pgm_byte(addrs[i], bytes[i]);
    end
    for (int seg = 0; seg < 2; seg++) begin
      mcu_load_ptr(addrs[4*seg]);
      check_eq("pointer msb after load", addrs[4*seg][13], status_out[6]);
      for (int k = 0; k < 4; k++) begin
        bus_read(reg_data, d);
        check_eq($sformatf("byte at %h", addrs[4*seg+k]), bytes[4*seg+k], d);
        next = addrs[4*seg+k] + 1'b1;
        check_eq("pointer msb", next[13], status_out[6]);
      end
    end
    finish_test();
  endtask

  task automatic disabled_bus();
    logic [31:0] a;
    logic [15:0] t;
    logic [7:0]  v;
    logic [6:0]  st;
    logic [7:0]  d_before;
    logic [7:0]  d;
    start_test("disabled_bus");
    bus_read(reg_status, d_before);
    a = addr_out;
    t = track_out;
    v = volume_out;
    st = status_out;
    @(negedge clkin);
    enable = 1'b0;
    bus_write(reg_seek0, ~a[7:0]);
    bus_write(reg_seek3, ~a[31:24]);
    bus_write(reg_volume, ~v);
    // Latch would still be high here had the write got through
    check_eq("volume latch", 0, volume_latch_out);
    bus_write(reg_track1, ~t[15:8]);
    bus_read(3'd2, d);
    bus_read(reg_data, d);
    check_eq("addr_out", a, addr_out);
    check_eq("track_out", t, track_out);
    check_eq("volume_out", v, volume_out);
    check_eq("status_out", st, status_out);
    check_eq("reg_data_out", d_before, reg_data_out);
    @(negedge clkin);
    enable = 1'b1;
    finish_test();
  endtask

  //////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////

  initial begin
    void'($urandom(78));
    clkin = 1'b0;
    rst = 1'b1;
    enable = 1'b1;
    pgm_address = '0;
    pgm_data = '0;
    pgm_we = 1'b1;
    reg_addr = '0;
    reg_data_in = '0;
    reg_oe_falling = 1'b0;
    reg_oe_rising = 1'b0;
    reg_we_rising = 1'b0;
    status_set_bits = '0;
    status_reset_bits = '0;
    status_reset_we = 1'b0;
    msu_address_ext = '0;
    msu_address_ext_write = 1'b0;
    errors = 0;
    pass_count = 0;
    fail_count = 0;
    exp_flags = 6'b110000;
    exp_astart = 1'b0;
    exp_dstart = 1'b0;
    exp_actrl = 2'b00;
    repeat (2) @(negedge clkin);
    rst = 1'b0;

    reset_values();
    host_writes();
    status_set_reset();
    control_gating();
    buffer_stream();
    disabled_bus();

    if (i_msu.i_checker.violations != 0) begin
      $display("Concurrent checker reported %0d violations", i_msu.i_checker.violations);
      errors += i_msu.i_checker.violations;
    end
    $display("Tests passed: %0d, failed: %0d", pass_count, fail_count);
    if (errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule
